// File: hw/crypto_pkg.sv
`default_nettype none

package crypto_pkg;

    // data word between memory and sponge
    typedef logic [15:0] word_t;

    // byte address
    typedef logic [15:0] addr_t;

    localparam int security_bits = 64;

    // tag length in bytes
    localparam addr_t tag_bytes = addr_t'(security_bits / 8);

    // address step per word
    localparam addr_t word_bytes = 16'd2;

    typedef enum logic [3:0] {
        idle,
        check_sm,
        ad_init,
        ad_load,
        ad_wait,
        body_init,
        body_load,
        body_wait,
        tag_init,
        tag_write,
        tag_write_wait,
        tag_verify,
        tag_verify_wait,
        fail,
        success
    } wrap_state_t;

endpackage

`default_nettype wire

// File: hw/sm_pkg.sv
`default_nettype none

package sm_pkg;

    // what the module table puts on sm_data
    typedef enum logic [2:0] {
        req_none = 3'd0,
        req_id   = 3'd1
    } sm_request_t;

    // module id word
    typedef logic [15:0] sm_id_t;

endpackage

`default_nettype wire

// File: hw/address_counters.sv
`timescale 1ns/1ps
`default_nettype none

module address_counters (
    input  wire                     clk,
    input  wire                     ctr_init,
    input  wire                     ctr_inc,
    input  wire                     limit_init,
    input  wire                     cipher_init,
    input  wire                     cipher_inc,
    input  wire                     select_cipher,
    input  wire crypto_pkg::addr_t  ctr_base,
    input  wire crypto_pkg::addr_t  limit,
    input  wire crypto_pkg::addr_t  cipher_base,
    output logic                    mem_done,
    output crypto_pkg::addr_t       mab
);

    crypto_pkg::addr_t ctr;
    crypto_pkg::addr_t limit_reg;
    crypto_pkg::addr_t cipher_ctr;

    // read address over the current range
    always_ff @(posedge clk)
    begin
        if (ctr_init)
            ctr <= ctr_base;
        else if (ctr_inc)
            ctr <= ctr + crypto_pkg::word_bytes;
    end

    always_ff @(posedge clk)
    begin
        if (limit_init)
            limit_reg <= limit;
    end

    // output address for cipher words
    always_ff @(posedge clk)
    begin
        if (cipher_init)
            cipher_ctr <= cipher_base;
        else if (cipher_inc)
            cipher_ctr <= cipher_ctr + crypto_pkg::word_bytes;
    end

    // an empty range counts as done at once
    assign mem_done = ctr >= limit_reg;

    assign mab = select_cipher ? cipher_ctr : ctr;

endmodule

`default_nettype wire

// File: hw/wrap_feed.sv
`timescale 1ns/1ps
`default_nettype none

module wrap_feed (
    input  wire                     clk,
    input  wire                     reset,
    input  wire crypto_pkg::word_t  data_val,
    input  wire                     update,
    input  wire                     set_start,
    input  wire crypto_pkg::word_t  mem_in,
    input  wire crypto_pkg::word_t  wrap_data_out,
    input  wire                     wrap_data_out_ready,
    output crypto_pkg::word_t       wrap_data_in,
    output logic                    wrap_start_continue,
    output logic                    tag_ok
);

    // next sponge input word
    always_ff @(posedge clk)
    begin
        if (update)
            wrap_data_in <= data_val;
    end

    // start pulse lands one cycle after the request
    always_ff @(posedge clk)
    begin
        if (reset)
            wrap_start_continue <= 1'b0;
        else
            wrap_start_continue <= set_start;
    end

    // only a ready word can mismatch
    assign tag_ok = !wrap_data_out_ready || (wrap_data_out == mem_in);

endmodule

`default_nettype wire

// File: hw/wrap_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module wrap_sequencer (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     start,
    input  wire                     cmd_wrap,
    input  wire                     cmd_unwrap,
    input  wire                     cmd_id,
    input  wire crypto_pkg::addr_t  r10,
    input  wire crypto_pkg::addr_t  r11,
    input  wire crypto_pkg::addr_t  r12,
    input  wire crypto_pkg::addr_t  r13,
    input  wire crypto_pkg::addr_t  r14,
    input  wire crypto_pkg::addr_t  r15,
    input  wire crypto_pkg::word_t  mem_in,
    input  wire sm_pkg::sm_id_t     sm_data,
    input  wire                     sm_data_select_valid,
    input  wire                     sm_key_select_valid,
    input  wire                     wrap_busy,
    input  wire                     wrap_data_out_ready,
    input  wire crypto_pkg::word_t  wrap_data_out,
    input  wire                     mem_done,
    input  wire                     tag_ok,
    output logic                    busy,
    output logic                    reg_write,
    output logic                    mb_en,
    output logic [1:0]              mb_wr,
    output crypto_pkg::word_t       data_out,
    output sm_pkg::sm_request_t     sm_request,
    output logic                    wrap_reset,
    output logic                    wrap_last_block,
    output logic                    ctr_init,
    output logic                    ctr_inc,
    output crypto_pkg::addr_t       ctr_base,
    output logic                    limit_init,
    output crypto_pkg::addr_t       limit,
    output logic                    cipher_init,
    output logic                    cipher_inc,
    output crypto_pkg::addr_t       cipher_base,
    output logic                    select_cipher,
    output crypto_pkg::word_t       data_val,
    output logic                    update,
    output logic                    set_start
);

    crypto_pkg::wrap_state_t state;
    crypto_pkg::wrap_state_t next_state;

    logic do_wrap;
    logic sm_valid;

    assign do_wrap = cmd_wrap | cmd_unwrap;

    // wrap and unwrap need a key and identity needs module data
    assign sm_valid = (!cmd_id || sm_data_select_valid) &&
                      (!do_wrap || sm_key_select_valid);

    always_comb
    begin
        next_state = state;
        case (state)
            crypto_pkg::idle:
                next_state = start ? crypto_pkg::check_sm : crypto_pkg::idle;
            crypto_pkg::check_sm:
                if (!sm_valid)
                    next_state = crypto_pkg::fail;
                else if (do_wrap)
                    next_state = crypto_pkg::ad_init;
                else if (cmd_id)
                    next_state = crypto_pkg::success;
                else
                    next_state = crypto_pkg::fail;
            crypto_pkg::ad_init,
            crypto_pkg::ad_load:
                next_state = crypto_pkg::ad_wait;
            crypto_pkg::ad_wait:
                if (wrap_busy)
                    next_state = crypto_pkg::ad_wait;
                else if (!mem_done)
                    next_state = crypto_pkg::ad_load;
                else
                    next_state = crypto_pkg::body_init;
            crypto_pkg::body_init,
            crypto_pkg::body_load:
                next_state = crypto_pkg::body_wait;
            crypto_pkg::body_wait:
                if (wrap_busy)
                    next_state = crypto_pkg::body_wait;
                else if (mem_done)
                    next_state = crypto_pkg::tag_init;
                else
                    next_state = crypto_pkg::body_load;
            crypto_pkg::tag_init:
                next_state = cmd_wrap ? crypto_pkg::tag_write_wait
                                      : crypto_pkg::tag_verify_wait;
            crypto_pkg::tag_write:
                next_state = crypto_pkg::tag_write_wait;
            crypto_pkg::tag_write_wait:
                if (wrap_busy)
                    next_state = crypto_pkg::tag_write_wait;
                else if (mem_done)
                    next_state = crypto_pkg::success;
                else
                    next_state = crypto_pkg::tag_write;
            crypto_pkg::tag_verify:
                next_state = tag_ok ? crypto_pkg::tag_verify_wait : crypto_pkg::fail;
            crypto_pkg::tag_verify_wait:
                if (!tag_ok)
                    next_state = crypto_pkg::fail;
                else if (wrap_busy)
                    next_state = crypto_pkg::tag_verify_wait;
                else if (mem_done)
                    next_state = crypto_pkg::success;
                else
                    next_state = crypto_pkg::tag_verify;
            crypto_pkg::fail,
            crypto_pkg::success:
                next_state = crypto_pkg::idle;
            default:
                next_state = crypto_pkg::idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= crypto_pkg::idle;
        else
            state <= next_state;
    end

    // controls follow the state being entered
    always_comb
    begin
        busy = 1'b1;
        reg_write = 1'b0;
        mb_en = 1'b0;
        mb_wr = 2'b00;
        data_out = '0;
        sm_request = sm_pkg::req_none;
        wrap_reset = 1'b0;
        wrap_last_block = 1'b0;
        ctr_init = 1'b0;
        ctr_inc = 1'b0;
        ctr_base = '0;
        limit_init = 1'b0;
        limit = '0;
        cipher_init = 1'b0;
        cipher_inc = 1'b0;
        cipher_base = '0;
        select_cipher = 1'b0;
        data_val = '0;
        update = 1'b0;
        set_start = 1'b0;

        case (next_state)
            crypto_pkg::idle:
            begin
                busy = 1'b0;
                wrap_reset = 1'b1;
            end
            crypto_pkg::ad_init:
            begin
                ctr_init = 1'b1;
                ctr_base = r10;
                limit_init = 1'b1;
                limit = r11;
            end
            crypto_pkg::ad_load,
            crypto_pkg::body_load:
            begin
                data_val = mem_in;
                update = 1'b1;
                set_start = 1'b1;
                ctr_inc = 1'b1;
            end
            crypto_pkg::ad_wait:
            begin
                mb_en = 1'b1;
                wrap_last_block = mem_done;
            end
            crypto_pkg::body_init:
            begin
                ctr_init = 1'b1;
                ctr_base = r12;
                limit_init = 1'b1;
                limit = r13;
                cipher_init = 1'b1;
                cipher_base = r14;
            end
            crypto_pkg::body_wait:
            begin
                // ready word goes out to the cipher range
                mb_en = 1'b1;
                mb_wr = wrap_data_out_ready ? 2'b11 : 2'b00;
                select_cipher = wrap_data_out_ready;
                cipher_inc = wrap_data_out_ready;
                data_out = wrap_data_out;
                wrap_last_block = mem_done;
            end
            crypto_pkg::tag_init:
            begin
                ctr_init = 1'b1;
                ctr_base = r15;
                limit_init = 1'b1;
                limit = r15 + crypto_pkg::tag_bytes;
            end
            crypto_pkg::tag_write:
                set_start = 1'b1;
            crypto_pkg::tag_write_wait:
            begin
                mb_en = wrap_data_out_ready;
                mb_wr = wrap_data_out_ready ? 2'b11 : 2'b00;
                ctr_inc = wrap_data_out_ready;
                data_out = wrap_data_out;
            end
            crypto_pkg::tag_verify:
            begin
                set_start = 1'b1;
                mb_en = 1'b1;
            end
            crypto_pkg::tag_verify_wait:
            begin
                mb_en = 1'b1;
                ctr_inc = wrap_data_out_ready;
            end
            crypto_pkg::fail:
                reg_write = 1'b1;
            crypto_pkg::success:
            begin
                reg_write = 1'b1;
                sm_request = sm_pkg::req_id;
                data_out = cmd_id ? sm_data : 16'h0001;
            end
            default:
            begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/crypto_control.sv
`timescale 1ns/1ps
`default_nettype none

module crypto_control (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     start,
    input  wire                     cmd_wrap,
    input  wire                     cmd_unwrap,
    input  wire                     cmd_id,
    input  wire crypto_pkg::addr_t  r10,
    input  wire crypto_pkg::addr_t  r11,
    input  wire crypto_pkg::addr_t  r12,
    input  wire crypto_pkg::addr_t  r13,
    input  wire crypto_pkg::addr_t  r14,
    input  wire crypto_pkg::addr_t  r15,
    input  wire crypto_pkg::word_t  mem_in,
    input  wire sm_pkg::sm_id_t     sm_data,
    input  wire                     sm_data_select_valid,
    input  wire                     sm_key_select_valid,
    input  wire                     wrap_busy,
    input  wire crypto_pkg::word_t  wrap_data_out,
    input  wire                     wrap_data_out_ready,
    output logic                    busy,
    output logic                    reg_write,
    output crypto_pkg::word_t       data_out,
    output sm_pkg::sm_request_t     sm_request,
    output logic                    mb_en,
    output logic [1:0]              mb_wr,
    output crypto_pkg::addr_t       mab,
    output logic                    wrap_reset,
    output logic                    wrap_start_continue,
    output crypto_pkg::word_t       wrap_data_in,
    output logic                    wrap_last_block
);

    // counter controls
    logic              ctr_init;
    logic              ctr_inc;
    crypto_pkg::addr_t ctr_base;
    logic              limit_init;
    crypto_pkg::addr_t limit;
    logic              cipher_init;
    logic              cipher_inc;
    crypto_pkg::addr_t cipher_base;
    logic              select_cipher;
    logic              mem_done;

    // sponge feed controls
    crypto_pkg::word_t data_val;
    logic              update;
    logic              set_start;
    logic              tag_ok;

    wrap_sequencer sequencer_i (
        .clk                  (clk),
        .reset                (reset),
        .start                (start),
        .cmd_wrap             (cmd_wrap),
        .cmd_unwrap           (cmd_unwrap),
        .cmd_id               (cmd_id),
        .r10                  (r10),
        .r11                  (r11),
        .r12                  (r12),
        .r13                  (r13),
        .r14                  (r14),
        .r15                  (r15),
        .mem_in               (mem_in),
        .sm_data              (sm_data),
        .sm_data_select_valid (sm_data_select_valid),
        .sm_key_select_valid  (sm_key_select_valid),
        .wrap_busy            (wrap_busy),
        .wrap_data_out_ready  (wrap_data_out_ready),
        .wrap_data_out        (wrap_data_out),
        .mem_done             (mem_done),
        .tag_ok               (tag_ok),
        .busy                 (busy),
        .reg_write            (reg_write),
        .mb_en                (mb_en),
        .mb_wr                (mb_wr),
        .data_out             (data_out),
        .sm_request           (sm_request),
        .wrap_reset           (wrap_reset),
        .wrap_last_block      (wrap_last_block),
        .ctr_init             (ctr_init),
        .ctr_inc              (ctr_inc),
        .ctr_base             (ctr_base),
        .limit_init           (limit_init),
        .limit                (limit),
        .cipher_init          (cipher_init),
        .cipher_inc           (cipher_inc),
        .cipher_base          (cipher_base),
        .select_cipher        (select_cipher),
        .data_val             (data_val),
        .update               (update),
        .set_start            (set_start)
    );

    address_counters counters_i (
        .clk           (clk),
        .ctr_init      (ctr_init),
        .ctr_inc       (ctr_inc),
        .limit_init    (limit_init),
        .cipher_init   (cipher_init),
        .cipher_inc    (cipher_inc),
        .select_cipher (select_cipher),
        .ctr_base      (ctr_base),
        .limit         (limit),
        .cipher_base   (cipher_base),
        .mem_done      (mem_done),
        .mab           (mab)
    );

    wrap_feed feed_i (
        .clk                 (clk),
        .reset               (reset),
        .data_val            (data_val),
        .update              (update),
        .set_start           (set_start),
        .mem_in              (mem_in),
        .wrap_data_out       (wrap_data_out),
        .wrap_data_out_ready (wrap_data_out_ready),
        .wrap_data_in        (wrap_data_in),
        .wrap_start_continue (wrap_start_continue),
        .tag_ok              (tag_ok)
    );

endmodule

`default_nettype wire

// File: testbench/crypto_control_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module crypto_control_assertions (
    input wire       clk,
    input wire       reset,
    input wire       start,
    input wire       busy,
    input wire       reg_write,
    input wire       mb_en,
    input wire [1:0] mb_wr
);

    int failures = 0;
    logic in_command;

    // from the sampled start up to the closing reg_write
    always_ff @(posedge clk)
    begin
        if (reset)
            in_command <= 1'b0;
        else if (reg_write)
            in_command <= 1'b0;
        else if (start)
            in_command <= 1'b1;
    end

    single_result_pulse: assert property (@(posedge clk) disable iff (reset)
        reg_write |=> !reg_write)
    else
    begin
        failures++;
        $error("reg_write stayed high for two cycles");
    end

    write_needs_enable: assert property (@(posedge clk) disable iff (reset)
        (mb_wr != 2'b00) |-> mb_en)
    else
    begin
        failures++;
        $error("mb_wr set while mb_en is low");
    end

    busy_during_command: assert property (@(posedge clk) disable iff (reset)
        (in_command && !reg_write) |-> busy)
    else
    begin
        failures++;
        $error("busy dropped in the middle of a command");
    end

endmodule

`default_nettype wire

// File: testbench/tb_crypto_control.sv
`timescale 1ns/1ps
`default_nettype none

module tb_crypto_control;

    localparam time clk_period = 100ns;
    // five tests of well under 150 cycles each
    localparam int max_cycles = 2000;
    localparam crypto_pkg::word_t keystream = 16'h5A3C;
    localparam crypto_pkg::word_t tag_base = 16'hC0DE;
    localparam crypto_pkg::addr_t ad_start = 16'h0040;
    localparam crypto_pkg::addr_t body_start = 16'h0080;
    localparam crypto_pkg::addr_t tag_addr = 16'h0140;
    localparam int ad_len = 2;
    localparam int body_len = 4;
    localparam int tag_len = 4;

    logic clk = 1'b0;
    logic reset;
    logic start;
    logic cmd_wrap;
    logic cmd_unwrap;
    logic cmd_id;
    crypto_pkg::addr_t r10;
    crypto_pkg::addr_t r11;
    crypto_pkg::addr_t r12;
    crypto_pkg::addr_t r13;
    crypto_pkg::addr_t r14;
    crypto_pkg::addr_t r15;
    crypto_pkg::word_t mem_in;
    sm_pkg::sm_id_t sm_data;
    logic sm_data_select_valid;
    logic sm_key_select_valid;
    logic wrap_busy;
    crypto_pkg::word_t wrap_data_out;
    logic wrap_data_out_ready;

    logic busy;
    logic reg_write;
    crypto_pkg::word_t data_out;
    sm_pkg::sm_request_t sm_request;
    logic mb_en;
    logic [1:0] mb_wr;
    crypto_pkg::addr_t mab;
    logic wrap_reset;
    logic wrap_start_continue;
    crypto_pkg::word_t wrap_data_in;
    logic wrap_last_block;

    crypto_pkg::word_t mem [0:255];
    crypto_pkg::word_t body_data [body_len];
    int error_count = 0;
    int check_count = 0;
    int cycle_count = 0;
    int seed = 75;

    // memory model state
    logic mem_rd;
    logic mem_wr;
    crypto_pkg::addr_t mem_addr;
    crypto_pkg::word_t mem_wdata;

    // sponge model state
    logic sp_start;
    logic sp_last;
    logic sp_reset;
    crypto_pkg::word_t sp_in;
    int sp_phase;
    int busy_left;
    crypto_pkg::word_t body_index;
    crypto_pkg::word_t tag_index;

    crypto_control dut_i (.*);

    bind crypto_control crypto_control_assertions assertions_i (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .busy      (busy),
        .reg_write (reg_write),
        .mb_en     (mb_en),
        .mb_wr     (mb_wr)
    );

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= max_cycles)
        begin
            $display("timeout: no command result after %0d cycles", cycle_count);
            $display("Result: FAILED");
            $finish;
        end
    end

    // word memory with reads one cycle late
    initial
    begin
        mem_in = '0;
        forever
        begin
            @(negedge clk);
            mem_rd = mb_en;
            mem_wr = mb_en && (mb_wr == 2'b11);
            mem_addr = mab;
            mem_wdata = data_out;
            @(posedge clk);
            #1;
            if (mem_wr)
                mem[mem_addr[8:1]] = mem_wdata;
            if (mem_rd)
                mem_in = mem[mem_addr[8:1]];
        end
    end

    // sponge model holds busy 3 cycles per block and emits in the first
    initial
    begin
        wrap_busy = 1'b0;
        wrap_data_out = '0;
        wrap_data_out_ready = 1'b0;
        forever
        begin
            @(negedge clk);
            sp_start = wrap_start_continue;
            sp_last = wrap_last_block;
            sp_in = wrap_data_in;
            sp_reset = wrap_reset || reset;
            @(posedge clk);
            #1;
            wrap_data_out_ready = 1'b0;
            if (sp_reset)
            begin
                sp_phase = 0;
                body_index = '0;
                tag_index = '0;
                busy_left = 0;
                wrap_busy = 1'b0;
            end
            else if (sp_start)
            begin
                busy_left = 3;
                wrap_busy = 1'b1;
                if (sp_phase == 0)
                begin
                    // associated data gives no output
                    if (sp_last)
                        sp_phase = 1;
                end
                else if (sp_phase == 1)
                begin
                    wrap_data_out = sp_in ^ keystream ^ body_index;
                    wrap_data_out_ready = 1'b1;
                    body_index++;
                    if (sp_last)
                        sp_phase = 2;
                end
                else
                begin
                    wrap_data_out = tag_base + tag_index;
                    wrap_data_out_ready = 1'b1;
                    tag_index++;
                end
            end
            else if (busy_left > 0)
            begin
                busy_left--;
                wrap_busy = (busy_left != 0);
            end
        end
    end

    task automatic expect_equal(input string what, input crypto_pkg::word_t got,
                                input crypto_pkg::word_t expected);
        check_count++;
        assert (got === expected)
        else
        begin
            error_count++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    function automatic crypto_pkg::word_t fill_value(input crypto_pkg::addr_t addr);
        return addr ^ 16'hA5A5;
    endfunction

    function automatic crypto_pkg::word_t word_at(input crypto_pkg::addr_t addr);
        return mem[addr[8:1]];
    endfunction

    task automatic store_word(input crypto_pkg::addr_t addr, input crypto_pkg::word_t value);
        mem[addr[8:1]] = value;
    endtask

    task automatic fill_memory;
        for (int i = 0; i < 256; i++)
            mem[i] = fill_value(crypto_pkg::addr_t'(i * 2));
    endtask

    // one-cycle start pulse and result taken in the reg_write cycle
    task automatic run_command(input logic wrap, input logic unwrap, input logic id,
                               output crypto_pkg::word_t result,
                               output sm_pkg::sm_request_t request, output int latency);
        @(posedge clk);
        #1;
        cmd_wrap = wrap;
        cmd_unwrap = unwrap;
        cmd_id = id;
        start = 1'b1;
        @(negedge clk);
        expect_equal("busy in the start cycle", busy, 1'b1);
        @(posedge clk);
        #1;
        start = 1'b0;
        latency = 1;
        @(negedge clk);
        while (!reg_write)
        begin
            @(negedge clk);
            latency++;
        end
        result = data_out;
        request = sm_request;
        @(negedge clk);
        expect_equal("reg_write after the result", reg_write, 1'b0);
        expect_equal("busy after the result", busy, 1'b0);
        @(posedge clk);
        #1;
        cmd_wrap = 1'b0;
        cmd_unwrap = 1'b0;
        cmd_id = 1'b0;
    endtask

    task automatic load_message(input crypto_pkg::addr_t out_start);
        fill_memory();
        r10 = ad_start;
        r11 = ad_start + 2 * ad_len;
        r12 = body_start;
        r13 = body_start + 2 * body_len;
        r14 = out_start;
        r15 = tag_addr;
        for (int i = 0; i < ad_len; i++)
            store_word(ad_start + 2 * i, 16'($random(seed)));
        for (int i = 0; i < body_len; i++)
        begin
            body_data[i] = 16'($random(seed));
            store_word(body_start + 2 * i, body_data[i]);
        end
        sm_key_select_valid = 1'b1;
    endtask

    task automatic check_body_output(input crypto_pkg::addr_t out_start);
        for (int i = 0; i < body_len; i++)
            expect_equal($sformatf("output word %0d", i), word_at(out_start + 2 * i),
                         body_data[i] ^ keystream ^ 16'(i));
        expect_equal("word after output range", word_at(out_start + 2 * body_len),
                     fill_value(out_start + 2 * body_len));
    endtask

    task automatic test_reset_and_identity;
        crypto_pkg::word_t result;
        sm_pkg::sm_request_t request;
        int latency;
        @(negedge clk);
        expect_equal("busy after reset", busy, 1'b0);
        expect_equal("reg_write after reset", reg_write, 1'b0);
        expect_equal("mb_en after reset", mb_en, 1'b0);
        expect_equal("sm_request after reset", sm_request, sm_pkg::req_none);
        @(posedge clk);
        #1;
        sm_data = 16'h3A51;
        sm_data_select_valid = 1'b1;
        run_command(1'b0, 1'b0, 1'b1, result, request, latency);
        expect_equal("identity latency", latency, 1);
        expect_equal("identity return", result, 16'h3A51);
        expect_equal("identity sm_request", request, sm_pkg::req_id);
    endtask

    task automatic test_missing_module;
        crypto_pkg::word_t result;
        sm_pkg::sm_request_t request;
        int latency;
        sm_data_select_valid = 1'b0;
        sm_key_select_valid = 1'b0;
        run_command(1'b0, 1'b0, 1'b1, result, request, latency);
        expect_equal("identity without data, latency", latency, 1);
        expect_equal("identity without data, return", result, 16'h0000);
        sm_data_select_valid = 1'b1;
        run_command(1'b1, 1'b0, 1'b0, result, request, latency);
        expect_equal("wrap without key, latency", latency, 1);
        expect_equal("wrap without key, return", result, 16'h0000);
    endtask

    task automatic test_wrap;
        crypto_pkg::word_t result;
        sm_pkg::sm_request_t request;
        int latency;
        load_message(16'h0100);
        run_command(1'b1, 1'b0, 1'b0, result, request, latency);
        expect_equal("wrap return", result, 16'h0001);
        check_body_output(16'h0100);
        for (int i = 0; i < tag_len; i++)
            expect_equal($sformatf("tag word %0d", i), word_at(tag_addr + 2 * i),
                         tag_base + 16'(i));
        expect_equal("word after tag", word_at(tag_addr + 2 * tag_len),
                     fill_value(tag_addr + 2 * tag_len));
    endtask

    // corrupt_index below zero keeps the stored tag intact
    task automatic test_unwrap(input int corrupt_index, input crypto_pkg::word_t expected);
        crypto_pkg::word_t result;
        sm_pkg::sm_request_t request;
        int latency;
        load_message(16'h0180);
        for (int i = 0; i < tag_len; i++)
            store_word(tag_addr + 2 * i, tag_base + 16'(i));
        if (corrupt_index >= 0)
            store_word(tag_addr + 2 * corrupt_index,
                       (tag_base + 16'(corrupt_index)) ^ 16'h0100);
        run_command(1'b0, 1'b1, 1'b0, result, request, latency);
        expect_equal("unwrap return", result, expected);
        if (corrupt_index < 0)
            check_body_output(16'h0180);
    endtask

    initial
    begin
        int assertion_failures;
        reset = 1'b1;
        start = 1'b0;
        cmd_wrap = 1'b0;
        cmd_unwrap = 1'b0;
        cmd_id = 1'b0;
        r10 = '0;
        r11 = '0;
        r12 = '0;
        r13 = '0;
        r14 = '0;
        r15 = '0;
        sm_data = '0;
        sm_data_select_valid = 1'b0;
        sm_key_select_valid = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        test_reset_and_identity();
        test_missing_module();
        test_wrap();
        test_unwrap(-1, 16'h0001);
        test_unwrap(2, 16'h0000);

        repeat (2) @(posedge clk);
        assertion_failures = dut_i.assertions_i.failures;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, assertion_failures);
        if (error_count == 0 && assertion_failures == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
hw/crypto_pkg.sv
hw/sm_pkg.sv
hw/address_counters.sv
hw/wrap_feed.sv
hw/wrap_sequencer.sv
hw/crypto_control.sv
testbench/crypto_control_assertions.sv
testbench/tb_crypto_control.sv

// File: Bender.yml
package:
  name: crypto_control

sources:
  - hw/crypto_pkg.sv
  - hw/sm_pkg.sv
  - hw/address_counters.sv
  - hw/wrap_feed.sv
  - hw/wrap_sequencer.sv
  - hw/crypto_control.sv
  - target: test
    files:
      - testbench/crypto_control_assertions.sv
      - testbench/tb_crypto_control.sv
